/* rtl/cnn_ctrl_pkg.sv */
`default_nettype none

package cnn_ctrl_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 4;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // register byte offsets
    localparam logic [ADDR_WIDTH-1:0] REG_CMD    = 4'h0;
    localparam logic [ADDR_WIDTH-1:0] REG_CFG1   = 4'h4;
    localparam logic [ADDR_WIDTH-1:0] REG_CFG2   = 4'h8;
    localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 4'hC;

    localparam logic [7:0] OPCODE_COMPUTE = 8'd87;
    localparam logic [1:0] RESP_OKAY      = 2'b00;

    typedef logic [11:0] chan_t;
    typedef logic [8:0]  dim_t;
    // one-hot, bit n-1 selects an n x n kernel
    typedef logic [4:0]  kernel_t;

    typedef struct packed {
        chan_t      in_ch;
        chan_t      out_ch;
        logic [1:0] operation;
        dim_t       ofmap_width;
        logic [2:0] stride;
        kernel_t    kernel;
    } layer_cfg_t;

    typedef struct packed {
        logic                  awvalid;
        logic [ADDR_WIDTH-1:0] awaddr;
        logic                  wvalid;
        logic [DATA_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] wstrb;
        logic                  bready;
        logic                  arvalid;
        logic [ADDR_WIDTH-1:0] araddr;
        logic                  rready;
    } axil_req_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [DATA_WIDTH-1:0] rdata;
        logic [1:0]            rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic transfer_start;
        logic preload;
        logic port_sel;
        logic load;
    } weight_ctrl_t;

    // kernel rows from the one-hot code, defaults to 1
    function automatic logic [2:0] kernel_rows(input kernel_t kernel);
        logic [2:0] rows;
        rows = 3'd1;
        for (int i = 0; i < 5; i++) begin
            if (kernel[i]) begin
                rows = 3'(i + 1);
            end
        end
        return rows;
    endfunction

endpackage

`default_nettype wire

/* rtl/ctrl_regs_axil.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs_axil
    import cnn_ctrl_pkg::*;
#(
    parameter int MAC_NUM = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axil_req_t          axil_req,
    input  logic               layer_done,
    output axil_rsp_t          axil_rsp,
    output layer_cfg_t         layer_cfg,
    output logic               compute_active,
    output logic [MAC_NUM-1:0] mac_enable
);

    logic [DATA_WIDTH-1:0] cmd_reg;
    logic [DATA_WIDTH-1:0] cfg1_reg;
    logic [DATA_WIDTH-1:0] cfg2_reg;
    logic [DATA_WIDTH-1:0] cmd_next;
    logic [DATA_WIDTH-1:0] rd_mux;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  done;
    logic                  bvalid;
    logic                  rvalid;
    logic                  wr_hs;
    logic                  rd_hs;
    logic                  cmd_wr;
    logic                  is_compute;

    function automatic logic [DATA_WIDTH-1:0] merge_strb(
        input logic [DATA_WIDTH-1:0] cur,
        input logic [DATA_WIDTH-1:0] wdata,
        input logic [STRB_WIDTH-1:0] strb
    );
        logic [DATA_WIDTH-1:0] res;
        res = cur;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // write channel
    ////////////////////////////////////////////////////////////

    // aw and w accepted together, one write in flight
    assign wr_hs      = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign cmd_wr     = wr_hs && (axil_req.awaddr == REG_CMD);
    assign cmd_next   = merge_strb(cmd_reg, axil_req.wdata, axil_req.wstrb);
    assign is_compute = (cmd_next[7:0] == OPCODE_COMPUTE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_reg  <= '0;
            cfg1_reg <= '0;
            cfg2_reg <= '0;
        end else if (wr_hs) begin
            case (axil_req.awaddr)
                REG_CMD:  cmd_reg  <= cmd_next;
                REG_CFG1: cfg1_reg <= merge_strb(cfg1_reg, axil_req.wdata, axil_req.wstrb);
                REG_CFG2: cfg2_reg <= merge_strb(cfg2_reg, axil_req.wdata, axil_req.wstrb);
                // status and holes are dropped
                default: ;
            endcase
        end
    end

    // start, abort and completion
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compute_active <= 1'b0;
            done           <= 1'b0;
        end else if (cmd_wr) begin
            compute_active <= is_compute;
            if (is_compute) begin
                done <= 1'b0;
            end
        end else if (layer_done) begin
            compute_active <= 1'b0;
            done           <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // read channel and responses
    ////////////////////////////////////////////////////////////

    assign rd_hs = axil_req.arvalid && !rvalid;

    always_comb begin
        case (axil_req.araddr)
            REG_CMD:    rd_mux = cmd_reg;
            REG_CFG1:   rd_mux = cfg1_reg;
            REG_CFG2:   rd_mux = cfg2_reg;
            REG_STATUS: rd_mux = {{(DATA_WIDTH-2){1'b0}}, compute_active, done};
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_hs) begin
            rdata <= rd_mux;
        end
    end

    assign axil_rsp.awready = wr_hs;
    assign axil_rsp.wready  = wr_hs;
    assign axil_rsp.bvalid  = bvalid;
    assign axil_rsp.bresp   = RESP_OKAY;
    assign axil_rsp.arready = rd_hs;
    assign axil_rsp.rvalid  = rvalid;
    assign axil_rsp.rdata   = rdata;
    assign axil_rsp.rresp   = RESP_OKAY;

    ////////////////////////////////////////////////////////////
    // config decode and lane mask
    ////////////////////////////////////////////////////////////

    assign layer_cfg.in_ch       = cmd_reg[19:8];
    assign layer_cfg.out_ch      = cmd_reg[31:20];
    assign layer_cfg.operation   = cfg1_reg[1:0];
    assign layer_cfg.ofmap_width = cfg1_reg[10:2];
    assign layer_cfg.stride      = cfg1_reg[13:11];
    assign layer_cfg.kernel      = cfg2_reg[4:0];

    // one lane per input channel
    always_comb begin
        for (int i = 0; i < MAC_NUM; i++) begin
            mac_enable[i] = (i < int'(layer_cfg.in_ch));
        end
    end

endmodule

`default_nettype wire

/* rtl/ifmap_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ifmap_sequencer
    import cnn_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       compute_active,
    input  layer_cfg_t layer_cfg,
    input  logic       ifmap_fifo_empty,
    input  logic       filters_done,
    output logic       load_ifmaps,
    output logic       compute_phase,
    output logic       layer_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_LOAD,
        S_COMPUTE
    } state_t;

    state_t     state;
    logic [2:0] fetch_left;
    dim_t       col;
    dim_t       row;
    dim_t       last_idx;
    logic       last_col;
    logic       last_pos;
    logic       pass_end;

    // square map, same bound for columns and rows
    assign last_idx = layer_cfg.ofmap_width - dim_t'(1);
    assign last_col = (col == last_idx);
    assign last_pos = last_col && (row == last_idx);
    assign pass_end = (state == S_COMPUTE) && filters_done;

    assign load_ifmaps   = (state == S_LOAD);
    assign compute_phase = (state == S_COMPUTE);
    assign layer_done    = pass_end && last_pos;

    ////////////////////////////////////////////////////////////
    // column fetch FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            fetch_left <= '0;
        end else if (!compute_active) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    state      <= S_WAIT;
                    fetch_left <= kernel_rows(layer_cfg.kernel);
                end
                S_WAIT: begin
                    if (!ifmap_fifo_empty) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    fetch_left <= fetch_left - 3'd1;
                    state      <= (fetch_left == 3'd1) ? S_COMPUTE : S_WAIT;
                end
                S_COMPUTE: begin
                    if (filters_done) begin
                        if (last_pos) begin
                            state <= S_IDLE;
                        end else begin
                            state <= S_WAIT;
                            // new row needs the whole window again
                            fetch_left <= last_col ? kernel_rows(layer_cfg.kernel) : 3'd1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // output position, advanced once per finished pass
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (state == S_IDLE) begin
            col <= '0;
            row <= '0;
        end else if (pass_end) begin
            if (last_col) begin
                col <= '0;
                row <= row + dim_t'(1);
            end else begin
                col <= col + dim_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/weight_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_sequencer
    import cnn_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         compute_active,
    input  layer_cfg_t   layer_cfg,
    input  logic         compute_phase,
    input  logic         weight_valid,
    output weight_ctrl_t weight_ctrl,
    output logic         filters_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_STEP,
        S_LOAD
    } state_t;

    state_t     state;
    logic [2:0] step;
    logic [2:0] last_step;
    chan_t      filter_cnt;
    logic       odd_step;
    logic       step_done;
    logic       last_filter;

    assign last_step   = kernel_rows(layer_cfg.kernel) - 3'd1;
    assign odd_step    = step[0];
    // even steps read BRAM and wait, odd steps take the other port
    assign step_done   = (state == S_STEP) && (odd_step || weight_valid);
    assign last_filter = (filter_cnt == layer_cfg.out_ch - chan_t'(1));

    always_comb begin
        weight_ctrl.transfer_start = (state == S_START);
        weight_ctrl.preload        = step_done;
        weight_ctrl.port_sel       = (state == S_STEP) && odd_step;
        weight_ctrl.load           = (state == S_LOAD);
    end

    assign filters_done = (state == S_LOAD) && last_filter;

    ////////////////////////////////////////////////////////////
    // kernel row FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            step       <= '0;
            filter_cnt <= '0;
        end else if (!compute_active) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    filter_cnt <= '0;
                    if (compute_phase) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    step  <= '0;
                    state <= S_STEP;
                end
                S_STEP: begin
                    if (step_done) begin
                        if (step == last_step) begin
                            state <= S_LOAD;
                        end else begin
                            step <= step + 3'd1;
                        end
                    end
                end
                S_LOAD: begin
                    // one filter done, next output channel
                    filter_cnt <= filter_cnt + chan_t'(1);
                    step       <= '0;
                    state      <= last_filter ? S_IDLE : S_STEP;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/cnn_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_ctrl_top
    import cnn_ctrl_pkg::*;
#(
    parameter int MAC_NUM = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axil_req_t          axil_req,
    input  logic               ifmap_fifo_empty,
    input  logic               weight_valid,
    output axil_rsp_t          axil_rsp,
    output logic               load_ifmaps,
    output weight_ctrl_t       weight_ctrl,
    output logic [MAC_NUM-1:0] mac_enable,
    output layer_cfg_t         layer_cfg,
    output logic               stream_en
);

    logic compute_active;
    logic compute_phase;
    logic filters_done;
    logic layer_done;

    // streaming follows the active layer
    assign stream_en = compute_active;

    ctrl_regs_axil #(
        .MAC_NUM (MAC_NUM)
    ) regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .axil_req       (axil_req),
        .layer_done     (layer_done),
        .axil_rsp       (axil_rsp),
        .layer_cfg      (layer_cfg),
        .compute_active (compute_active),
        .mac_enable     (mac_enable)
    );

    ifmap_sequencer ifmap_seq_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .compute_active   (compute_active),
        .layer_cfg        (layer_cfg),
        .ifmap_fifo_empty (ifmap_fifo_empty),
        .filters_done     (filters_done),
        .load_ifmaps      (load_ifmaps),
        .compute_phase    (compute_phase),
        .layer_done       (layer_done)
    );

    weight_sequencer weight_seq_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .compute_active (compute_active),
        .layer_cfg      (layer_cfg),
        .compute_phase  (compute_phase),
        .weight_valid   (weight_valid),
        .weight_ctrl    (weight_ctrl),
        .filters_done   (filters_done)
    );

endmodule

`default_nettype wire

/* dv/cnn_ctrl_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_ctrl_asserts
    import cnn_ctrl_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input axil_req_t    axil_req,
    input axil_rsp_t    axil_rsp,
    input logic         ifmap_fifo_empty,
    input logic         load_ifmaps,
    input weight_ctrl_t weight_ctrl
);

    // failures seen so far, read back by the testbench
    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite response stability
    ////////////////////////////////////////////////////////////

    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else begin
        $error("rvalid or rdata changed before rready");
        fail_count++;
    end

    ////////////////////////////////////////////////////////////
    // sequencer pulses
    ////////////////////////////////////////////////////////////

    fifo_before_load: assert property (@(posedge clk) disable iff (!rst_n)
        load_ifmaps |-> $past(!ifmap_fifo_empty))
    else begin
        $error("load_ifmaps without a non-empty FIFO the cycle before");
        fail_count++;
    end

    load_or_start: assert property (@(posedge clk) disable iff (!rst_n)
        !(weight_ctrl.load && weight_ctrl.transfer_start))
    else begin
        $error("load and transfer_start high together");
        fail_count++;
    end

    port_sel_preload: assert property (@(posedge clk) disable iff (!rst_n)
        weight_ctrl.port_sel |-> weight_ctrl.preload)
    else begin
        $error("port_sel without preload");
        fail_count++;
    end

endmodule

`default_nettype wire

/* dv/tb_cnn_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_ctrl
    import cnn_ctrl_pkg::*;
();

    localparam int MAC_NUM = 64;
    // longest layer is test 4, a few hundred cycles at full stall rate
    localparam int CYCLE_LIMIT = 20000;

    logic               clk;
    logic               rst_n;
    axil_req_t          axil_req;
    axil_rsp_t          axil_rsp;
    logic               ifmap_fifo_empty;
    logic               weight_valid;
    logic               load_ifmaps;
    weight_ctrl_t       weight_ctrl;
    logic [MAC_NUM-1:0] mac_enable;
    layer_cfg_t         layer_cfg;
    logic               stream_en;

    int          ifmap_cnt;
    int          start_cnt;
    int          load_cnt;
    int          preload_cnt;
    int          port_sel_cnt;
    int          errors;
    int          checks;
    int          tests_run;
    int          test_err_base;
    int          stream_drops;
    int          drop_load_cnt;
    bit          fifo_stall;
    bit          bram_stall;
    bit          bus_bp;
    bit          stream_watch;
    bit          stream_prev;
    logic [31:0] stall_rng;
    logic [31:0] bus_rng;
    logic [31:0] rd;
    int          lane_cases [4] = '{0, 1, 37, 64};

    cnn_ctrl_top #(
        .MAC_NUM (MAC_NUM)
    ) dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .axil_req         (axil_req),
        .ifmap_fifo_empty (ifmap_fifo_empty),
        .weight_valid     (weight_valid),
        .axil_rsp         (axil_rsp),
        .load_ifmaps      (load_ifmaps),
        .weight_ctrl      (weight_ctrl),
        .mac_enable       (mac_enable),
        .layer_cfg        (layer_cfg),
        .stream_en        (stream_en)
    );

    bind cnn_ctrl_top cnn_ctrl_asserts asserts_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .axil_req         (axil_req),
        .axil_rsp         (axil_rsp),
        .ifmap_fifo_empty (ifmap_fifo_empty),
        .load_ifmaps      (load_ifmaps),
        .weight_ctrl      (weight_ctrl)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] make_cmd(input logic [7:0] op, input int ic, input int oc);
        return {12'(oc), 12'(ic), op};
    endfunction

    function automatic int total_errors();
        return errors + dut_i.asserts_i.fail_count;
    endfunction

    ////////////////////////////////////////////////////////////
    // FIFO and BRAM models, pulse counters
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        stall_rng = xorshift32(stall_rng);
        ifmap_fifo_empty = fifo_stall && stall_rng[4];
        weight_valid     = !bram_stall || stall_rng[9];
    end

    always @(posedge clk) begin
        if (load_ifmaps) ifmap_cnt++;
        if (weight_ctrl.transfer_start) start_cnt++;
        if (weight_ctrl.load) load_cnt++;
        if (weight_ctrl.preload) preload_cnt++;
        if (weight_ctrl.port_sel) port_sel_cnt++;
        if (stream_watch) begin
            if (stream_prev && !stream_en) begin
                stream_drops++;
                drop_load_cnt = load_cnt;
            end
            stream_prev = stream_en;
        end
    end

    // hung run guard
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no result after %0d clock cycles", CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

    task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic clear_counts();
        ifmap_cnt    = 0;
        start_cnt    = 0;
        load_cnt     = 0;
        preload_cnt  = 0;
        port_sel_cnt = 0;
    endtask

    task automatic bus_delay();
        int n;
        bus_rng = xorshift32(bus_rng);
        n = bus_bp ? int'(bus_rng % 6) : 0;
        repeat (n) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // AXI4-Lite master, called and returning on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic axil_write(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = '1;
        @(posedge clk);
        while (!axil_rsp.awready) @(posedge clk);
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        bus_delay();
        axil_req.bready = 1'b1;
        @(posedge clk);
        while (!axil_rsp.bvalid) @(posedge clk);
        expect_eq("bresp", axil_rsp.bresp, RESP_OKAY);
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        @(posedge clk);
        while (!axil_rsp.arready) @(posedge clk);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        bus_delay();
        axil_req.rready = 1'b1;
        @(posedge clk);
        while (!axil_rsp.rvalid) @(posedge clk);
        data = axil_rsp.rdata;
        expect_eq("rresp", axil_rsp.rresp, RESP_OKAY);
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // layer helpers
    ////////////////////////////////////////////////////////////

    task automatic start_layer(input int k, input int w, input int oc);
        // stride 1, operation 0
        axil_write(REG_CFG1, (32'(w) << 2) | (32'd1 << 11));
        axil_write(REG_CFG2, 32'd1 << (k - 1));
        clear_counts();
        axil_write(REG_CMD, make_cmd(OPCODE_COMPUTE, 16, oc));
        expect_eq("layer_cfg.out_ch", layer_cfg.out_ch, oc);
    endtask

    task automatic wait_layer_done();
        logic [31:0] st;
        st = '0;
        while (!st[0]) axil_read(REG_STATUS, st);
        expect_eq("status.active", st[1], 1'b0);
    endtask

    // expected pulse totals, W*W passes per layer
    task automatic check_counts(input int k, input int w, input int oc);
        int passes;
        passes = w * w;
        expect_eq("load_ifmaps count", ifmap_cnt, w * (k + w - 1));
        expect_eq("transfer_start count", start_cnt, passes);
        expect_eq("load count", load_cnt, passes * oc);
        expect_eq("preload count", preload_cnt, passes * oc * k);
        expect_eq("port_sel count", port_sel_cnt, passes * oc * (k / 2));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name,
                 (total_errors() == test_err_base) ? "ok" : "FAILED");
        test_err_base = total_errors();
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        axil_req = '0;
        ifmap_fifo_empty = 1'b0;
        weight_valid = 1'b1;
        {fifo_stall, bram_stall, bus_bp, stream_watch, stream_prev} = '0;
        {errors, checks, tests_run, test_err_base, stream_drops, drop_load_cnt} = '0;
        stall_rng = 32'd71975;
        bus_rng = 32'd71975 ^ 32'h9e37_79b9;
        clear_counts();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        axil_read(REG_STATUS, rd);
        expect_eq("status after reset", rd, 32'h0);
        axil_write(REG_CFG1, 32'h0000_2d55);
        axil_read(REG_CFG1, rd);
        expect_eq("cfg1", rd, 32'h0000_2d55);
        axil_write(REG_CFG2, 32'h0000_0004);
        axil_read(REG_CFG2, rd);
        expect_eq("cfg2", rd, 32'h0000_0004);
        // field decode of the two config words above
        expect_eq("layer_cfg.operation", layer_cfg.operation, 2'h1);
        expect_eq("layer_cfg.ofmap_width", layer_cfg.ofmap_width, 9'h155);
        expect_eq("layer_cfg.stride", layer_cfg.stride, 3'h5);
        expect_eq("layer_cfg.kernel", layer_cfg.kernel, 5'h04);
        axil_write(REG_STATUS, 32'hffff_ffff);
        axil_read(REG_STATUS, rd);
        expect_eq("status after write", rd, 32'h0);
        axil_read(4'h2, rd);
        expect_eq("unmapped read", rd, 32'h0);
        end_test("register access");

        foreach (lane_cases[i]) begin
            axil_write(REG_CMD, make_cmd(8'h00, lane_cases[i], 0));
            expect_eq("layer_cfg.in_ch", layer_cfg.in_ch, lane_cases[i]);
            expect_eq("mac_enable", mac_enable,
                      (lane_cases[i] >= 64) ? '1 : (64'd1 << lane_cases[i]) - 64'd1);
        end
        end_test("lane mask");

        start_layer(1, 2, 2);
        wait_layer_done();
        check_counts(1, 2, 2);
        end_test("k1 w2 no stalls");

        fifo_stall = 1'b1;
        bram_stall = 1'b1;
        start_layer(3, 3, 3);
        wait_layer_done();
        check_counts(3, 3, 3);
        fifo_stall = 1'b0;
        bram_stall = 1'b0;
        end_test("k3 w3 fifo and bram stalls");

        bus_bp = 1'b1;
        start_layer(5, 2, 1);
        expect_eq("stream_en", stream_en, 1'b1);
        stream_prev = 1'b1;
        stream_drops = 0;
        stream_watch = 1'b1;
        wait_layer_done();
        stream_watch = 1'b0;
        // one drop only, after the last filter load
        expect_eq("stream_en drops", stream_drops, 1);
        expect_eq("load count at stream_en drop", drop_load_cnt, 2 * 2 * 1);
        check_counts(5, 2, 1);
        bus_bp = 1'b0;
        end_test("k5 w2 bus back-pressure");

        start_layer(3, 3, 3);
        while (ifmap_cnt < 4) @(negedge clk);
        axil_write(REG_CMD, make_cmd(8'h00, 0, 0));
        expect_eq("stream_en after abort", stream_en, 1'b0);
        @(negedge clk);
        clear_counts();
        repeat (40) @(negedge clk);
        expect_eq("load_ifmaps after abort", ifmap_cnt, 0);
        expect_eq("transfer_start after abort", start_cnt, 0);
        expect_eq("load after abort", load_cnt, 0);
        expect_eq("preload after abort", preload_cnt, 0);
        expect_eq("port_sel after abort", port_sel_cnt, 0);
        axil_read(REG_STATUS, rd);
        expect_eq("status after abort", rd, 32'h0);
        end_test("abort");

        $display("tests %0d, checks %0d, check errors %0d, assertion errors %0d",
                 tests_run, checks, errors, dut_i.asserts_i.fail_count);
        if (total_errors() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
rtl/cnn_ctrl_pkg.sv
rtl/ctrl_regs_axil.sv
rtl/ifmap_sequencer.sv
rtl/weight_sequencer.sv
rtl/cnn_ctrl_top.sv
dv/cnn_ctrl_asserts.sv
dv/tb_cnn_ctrl.sv
